//--- Makefile
# Verilator build, run and lint for the instruction front end

VERILATOR ?= verilator
TOP       ?= tb_frontend
RTL_TOP   ?= frontend_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= === PASS ===

RTL_SRCS := $(shell grep '^hdl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
hdl/drac_pkg.sv
hdl/riscv_pkg.sv
hdl/frontend_ctrl_if.sv
hdl/control_unit.sv
hdl/if_stage.sv
hdl/id_stage.sv
hdl/frontend_top.sv
tests/tb_frontend.sv

//--- hdl/control_unit.sv
// front end control unit
// picks each cycle whether the pc holds, advances or jumps,
// which source a jump takes its target from, and when decode is flushed

`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic            clk_i,
    input  logic            rst_n_i,
    frontend_ctrl_if.cu     ctrl,
    input  logic            valid_fetch_i,
    input  logic            wb_valid_i,
    input  logic            wb_change_pc_i
);
    import drac_pkg::*;

    // commit redirect is older than anything in the front end
    logic commit_jump;
    // any source asks for a jump
    logic jump;

    assign commit_jump = wb_valid_i && wb_change_pc_i;
    assign jump        = commit_jump || ctrl.valid_jal;

    // jump first, then hold on an empty fetch, else advance
    always_comb begin
        if (jump) begin
            // target source is chosen in the block below
            ctrl.next_pc = NEXT_PC_SEL_JUMP;
        end else if (!valid_fetch_i) begin
            // memory had no word so retry the same address
            ctrl.next_pc = NEXT_PC_SEL_PC;
        end else begin
            ctrl.next_pc = NEXT_PC_SEL_PC_4;
        end
    end

    // jump source
    always_comb begin
        // decode target only when commit is quiet
        if (ctrl.valid_jal && !commit_jump) begin
            ctrl.sel_addr_if = SEL_JUMP_DECODE;
        end else begin
            ctrl.sel_addr_if = SEL_JUMP_COMMIT;
        end
    end

    // word in fetch is on the wrong path in every jump cycle
    assign ctrl.flush_id = jump;

endmodule

`default_nettype wire

//--- hdl/drac_pkg.sv
// pipeline control definitions for the instruction front end
// covers addresses, next-pc selection, jump source selection and the reset pc
// imported by the control unit, fetch, decode and the control interface

`default_nettype none

package drac_pkg;

    // address width of the core
    localparam int unsigned ADDR_WIDTH = 64;

    // instruction address, also used for pc values
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // how the pc moves at the next edge
    typedef enum logic [1:0] {
        // keep the current pc, nothing was fetched
        NEXT_PC_SEL_PC   = 2'b00,
        // sequential advance by one instruction
        NEXT_PC_SEL_PC_4 = 2'b01,
        // load the selected jump target
        NEXT_PC_SEL_JUMP = 2'b10
    } next_pc_sel_t;

    // where a jump target comes from
    typedef enum logic {
        // jal resolved early in decode
        SEL_JUMP_DECODE = 1'b0,
        // redirect reported by writeback
        SEL_JUMP_COMMIT = 1'b1
    } sel_addr_if_t;

    // first fetch address after reset
    localparam addr_t RESET_PC = addr_t'(64'h0000_0000_0000_1000);

endpackage

`default_nettype wire

//--- hdl/frontend_ctrl_if.sv
// control bundle between the control unit, fetch and decode
// the control unit drives the pc selection and the decode flush,
// decode reports an early jal and its target

`timescale 1ns/1ps
`default_nettype none

interface frontend_ctrl_if;
    import drac_pkg::*;

    // pc selection for the next edge
    next_pc_sel_t next_pc;
    // jump source, decode or commit
    sel_addr_if_t sel_addr_if;
    // kill the fetch-to-decode path this cycle
    logic         flush_id;
    // decode holds a valid jal
    logic         valid_jal;
    // pc-relative target of that jal
    addr_t        jal_target;

    modport cu     (output next_pc, sel_addr_if, flush_id, input valid_jal);
    modport fetch  (input next_pc, sel_addr_if, jal_target);
    modport decode (input flush_id, output valid_jal, jal_target);

endinterface

`default_nettype wire

//--- hdl/frontend_top.sv
// instruction front end top level
// joins control unit, fetch and decode through the control interface
// instruction memory and the commit redirect attach as plain ports
// memory answers combinationally to fetch_addr_o

`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // instruction memory response
    input  logic                valid_fetch_i,
    input  riscv_pkg::instr_t   instr_i,
    // redirect from writeback
    input  logic                wb_valid_i,
    input  logic                wb_change_pc_i,
    input  drac_pkg::addr_t     wb_target_i,
    // instruction memory request
    output drac_pkg::addr_t     fetch_addr_o,
    // decoded instruction
    output logic                dec_valid_o,
    output drac_pkg::addr_t     dec_pc_o,
    output riscv_pkg::instr_t   dec_instr_o
);
    import drac_pkg::*;
    import riscv_pkg::*;

    // fetch-to-decode register outputs
    logic   if_valid;
    addr_t  if_pc;
    instr_t if_instr;

    frontend_ctrl_if ctrl_if ();

    control_unit u_control_unit (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ctrl           (ctrl_if.cu),
        .valid_fetch_i  (valid_fetch_i),
        .wb_valid_i     (wb_valid_i),
        .wb_change_pc_i (wb_change_pc_i)
    );

    if_stage u_if_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ctrl           (ctrl_if.fetch),
        .wb_target_i    (wb_target_i),
        .instr_i        (instr_i),
        .valid_fetch_i  (valid_fetch_i),
        .fetch_addr_o   (fetch_addr_o),
        .if_valid_o     (if_valid),
        .if_pc_o        (if_pc),
        .if_instr_o     (if_instr),
        .flush_id_i     (ctrl_if.flush_id)
    );

    id_stage u_id_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ctrl           (ctrl_if.decode),
        .if_valid_i     (if_valid),
        .if_pc_i        (if_pc),
        .if_instr_i     (if_instr),
        .dec_valid_o    (dec_valid_o),
        .dec_pc_o       (dec_pc_o),
        .dec_instr_o    (dec_instr_o)
    );

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
// decode stage
// spots jal in the registered fetch word and computes its target
// so the control unit can jump one cycle after the fetch
// passes the word on, invalid while a commit redirect is active

`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    frontend_ctrl_if.decode     ctrl,
    input  logic                if_valid_i,
    input  drac_pkg::addr_t     if_pc_i,
    input  riscv_pkg::instr_t   if_instr_i,
    output logic                dec_valid_o,
    output drac_pkg::addr_t     dec_pc_o,
    output riscv_pkg::instr_t   dec_instr_o
);
    import drac_pkg::*;
    import riscv_pkg::*;

    // major opcode of the word
    opcode_t opcode;
    // sign-extended j-type immediate
    addr_t   jal_imm;
    // flush raised by commit rather than by our own jal
    logic    commit_flush;

    assign opcode = if_instr_i[OPCODE_WIDTH-1:0];

    // imm[20|10:1|11|19:12] packed in bits 31:12, low bit always zero
    assign jal_imm = {{43{if_instr_i[31]}},
                      if_instr_i[31],
                      if_instr_i[19:12],
                      if_instr_i[20],
                      if_instr_i[30:21],
                      1'b0};

    // early jal, only for a valid word
    assign ctrl.valid_jal  = if_valid_i && (opcode == OP_JAL);
    assign ctrl.jal_target = if_pc_i + jal_imm;

    // shared flush line, a jal flush keeps the jal itself
    assign commit_flush = ctrl.flush_id && !ctrl.valid_jal;

    // word is younger than a commit redirect, drop it
    assign dec_valid_o = if_valid_i && !commit_flush;
    assign dec_pc_o    = if_pc_i;
    assign dec_instr_o = if_instr_i;

endmodule

`default_nettype wire

//--- hdl/if_stage.sv
// fetch stage
// keeps the pc, drives the instruction memory address and registers
// each accepted word with its pc for decode
// the pc moves as the control unit selects

`timescale 1ns/1ps
`default_nettype none

module if_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    frontend_ctrl_if.fetch      ctrl,
    input  drac_pkg::addr_t     wb_target_i,
    input  riscv_pkg::instr_t   instr_i,
    input  logic                valid_fetch_i,
    output drac_pkg::addr_t     fetch_addr_o,
    output logic                if_valid_o,
    output drac_pkg::addr_t     if_pc_o,
    output riscv_pkg::instr_t   if_instr_o,
    input  logic                flush_id_i
);
    import drac_pkg::*;
    import riscv_pkg::*;

    // pc register and its next value
    addr_t  pc_q;
    addr_t  pc_d;
    // selected jump target
    addr_t  jump_target;

    // fetch-to-decode register
    logic   if_valid_q;
    addr_t  if_pc_q;
    instr_t if_instr_q;

    // word is taken only when present and not flushed
    logic   accept;

    assign accept = valid_fetch_i && !flush_id_i;

    // next pc mux
    always_comb begin
        if (ctrl.sel_addr_if == SEL_JUMP_DECODE) begin
            jump_target = ctrl.jal_target;
        end else begin
            jump_target = wb_target_i;
        end

        case (ctrl.next_pc)
            NEXT_PC_SEL_JUMP: pc_d = jump_target;
            NEXT_PC_SEL_PC_4: pc_d = pc_q + addr_t'(INSTR_BYTES);
            default:          pc_d = pc_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // valid bit, cleared on flush or an empty fetch
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_valid_q <= 1'b0;
        end else begin
            if_valid_q <= accept;
        end
    end

    // payload, only meaningful with the valid bit
    always_ff @(posedge clk_i) begin
        if (accept) begin
            if_pc_q    <= pc_q;
            if_instr_q <= instr_i;
        end
    end

    // memory address is the pc itself
    assign fetch_addr_o = pc_q;
    assign if_valid_o   = if_valid_q;
    assign if_pc_o      = if_pc_q;
    assign if_instr_o   = if_instr_q;

endmodule

`default_nettype wire

//--- hdl/riscv_pkg.sv
// risc-v isa definitions used by the front end
// instruction word and opcode types, the jal opcode and the instruction size
// imported by fetch and decode

`default_nettype none

package riscv_pkg;

    // base isa instruction width, no compressed support
    localparam int unsigned INSTR_WIDTH = 32;

    // opcode sits in the low bits of every word
    localparam int unsigned OPCODE_WIDTH = 7;

    // one instruction word
    typedef logic [INSTR_WIDTH-1:0] instr_t;

    // major opcode field
    typedef logic [OPCODE_WIDTH-1:0] opcode_t;

    // jump and link, j-type format
    localparam opcode_t OP_JAL = 7'b1101111;

    // pc step between sequential instructions
    localparam int unsigned INSTR_BYTES = 4;

endpackage

`default_nettype wire

//--- tests/tb_frontend.sv
// directed testbench for the instruction front end
// a memory model answers fetch_addr_o in the same cycle and can hold one injected jal
// covers reset, sequential fetch with gaps, decode jal, commit redirect and priority

`timescale 1ns/1ps
`default_nettype none

module tb_frontend;
    import drac_pkg::*;
    import riscv_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int SEQ_WORDS    = 16;
    localparam int SEQ_TIMEOUT  = 200;
    // forward and backward jal offsets
    localparam logic [20:0] FWD_IMM  = 21'h000120;
    localparam logic [20:0] BACK_IMM = 21'h1fff00;
    localparam addr_t REDIRECT_PC = 64'h0000_0000_0000_4000;
    localparam addr_t PRIO_PC     = 64'h0000_0000_0000_8000;

    logic   clk_i;
    logic   rst_n_i;
    logic   valid_fetch_i;
    instr_t instr_i;
    logic   wb_valid_i;
    logic   wb_change_pc_i;
    addr_t  wb_target_i;
    addr_t  fetch_addr_o;
    logic   dec_valid_o;
    addr_t  dec_pc_o;
    instr_t dec_instr_o;

    // injected jal in the memory model
    logic   jal_armed;
    addr_t  jal_addr;
    instr_t jal_word;

    int     errors;
    int     checks;
    int     tests;
    int     test_first_error;
    logic   timed_out;

    frontend_top dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_fetch_i  (valid_fetch_i),
        .instr_i        (instr_i),
        .wb_valid_i     (wb_valid_i),
        .wb_change_pc_i (wb_change_pc_i),
        .wb_target_i    (wb_target_i),
        .fetch_addr_o   (fetch_addr_o),
        .dec_valid_o    (dec_valid_o),
        .dec_pc_o       (dec_pc_o),
        .dec_instr_o    (dec_instr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // addi-type word with every address bit folded in
    function automatic instr_t mem_word(input addr_t addr);
        logic [31:0] x;
        x = addr[63:32] ^ addr[31:0];
        if (jal_armed && addr == jal_addr) begin
            return jal_word;
        end
        return {x[31:7] ^ {18'd0, x[6:0]}, 7'b0010011};
    endfunction

    // j-type layout imm[20|10:1|11|19:12] with rd = x1
    function automatic instr_t encode_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OP_JAL};
    endfunction

    // 21-bit jal offset widened to an address
    function automatic addr_t sext_imm(input logic [20:0] imm);
        return {{43{imm[20]}}, imm};
    endfunction

    task automatic arm_jal(input addr_t addr, input instr_t word);
        jal_addr  = addr;
        jal_word  = word;
        jal_armed = 1'b1;
    endtask

    // drive one cycle on the falling edge and let outputs settle
    task automatic drive_cycle(input logic fetch_valid, input logic redirect, input addr_t target);
        @(negedge clk_i);
        valid_fetch_i  = fetch_valid;
        instr_i        = fetch_valid ? mem_word(fetch_addr_o) : '0;
        wb_valid_i     = redirect;
        wb_change_pc_i = redirect;
        wb_target_i    = target;
        #(CLK_PERIOD / 4);
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_instr(input string name, input instr_t got, input instr_t exp);
        checks++;
        if (got !== exp) begin
            $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("error t=%0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic start_test();
        test_first_error = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_first_error) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_first_error);
        end
    endtask

    task automatic test_reset();
        start_test();
        rst_n_i = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk_i);
        end
        check_addr("fetch_addr_o", fetch_addr_o, RESET_PC);
        check_bit("dec_valid_o", dec_valid_o, 1'b0);
        // release on the falling edge
        rst_n_i = 1'b1;
        #(CLK_PERIOD / 4);
        check_addr("fetch_addr_o", fetch_addr_o, RESET_PC);
        check_bit("dec_valid_o", dec_valid_o, 1'b0);
        end_test("reset");
    endtask

    // pc moves only on accepted words and each shows up one cycle later
    task automatic test_sequential();
        addr_t  exp_pc;
        addr_t  held_pc;
        instr_t held_word;
        logic   held;
        logic   take;
        int     accepted;
        int     cycles;
        start_test();
        exp_pc    = RESET_PC;
        held_pc   = '0;
        held_word = '0;
        held      = 1'b0;
        accepted  = 0;
        cycles    = 0;
        while (accepted < SEQ_WORDS && cycles < SEQ_TIMEOUT) begin
            // roughly one cycle in four has no word
            take = ($urandom % 4) != 0;
            drive_cycle(take, 1'b0, '0);
            check_addr("fetch_addr_o", fetch_addr_o, exp_pc);
            check_bit("dec_valid_o", dec_valid_o, held);
            if (held) begin
                check_addr("dec_pc_o", dec_pc_o, held_pc);
                check_instr("dec_instr_o", dec_instr_o, held_word);
            end
            held = take;
            if (take) begin
                held_pc   = exp_pc;
                held_word = mem_word(exp_pc);
                exp_pc    = exp_pc + addr_t'(INSTR_BYTES);
                accepted++;
            end
            cycles++;
        end
        if (accepted < SEQ_WORDS) begin
            $display("timeout: sequential fetch accepted only %0d of %0d words",
                     accepted, SEQ_WORDS);
            timed_out = 1'b1;
        end
        end_test("sequential fetch");
    endtask

    task automatic test_decode_jal();
        addr_t  jal_pc;
        addr_t  target;
        instr_t word;
        start_test();
        drive_cycle(1'b1, 1'b0, '0);
        // jal sits at the next fetch address
        jal_pc = fetch_addr_o + addr_t'(INSTR_BYTES);
        word   = encode_jal(FWD_IMM);
        target = jal_pc + sext_imm(FWD_IMM);
        arm_jal(jal_pc, word);
        drive_cycle(1'b1, 1'b0, '0);
        check_addr("fetch_addr_o", fetch_addr_o, jal_pc);
        // jal in decode with a younger word in fetch
        drive_cycle(1'b1, 1'b0, '0);
        check_bit("dec_valid_o", dec_valid_o, 1'b1);
        check_addr("dec_pc_o", dec_pc_o, jal_pc);
        check_instr("dec_instr_o", dec_instr_o, word);
        // younger word was dropped
        drive_cycle(1'b1, 1'b0, '0);
        check_addr("fetch_addr_o", fetch_addr_o, target);
        check_bit("dec_valid_o", dec_valid_o, 1'b0);
        drive_cycle(1'b1, 1'b0, '0);
        check_bit("dec_valid_o", dec_valid_o, 1'b1);
        check_addr("dec_pc_o", dec_pc_o, target);
        check_instr("dec_instr_o", dec_instr_o, mem_word(target));
        jal_armed = 1'b0;
        end_test("decode jal");
    endtask

    task automatic test_commit_redirect();
        start_test();
        drive_cycle(1'b1, 1'b0, '0);
        // valid word in decode is killed by the redirect
        drive_cycle(1'b1, 1'b1, REDIRECT_PC);
        check_bit("dec_valid_o", dec_valid_o, 1'b0);
        drive_cycle(1'b1, 1'b0, '0);
        check_addr("fetch_addr_o", fetch_addr_o, REDIRECT_PC);
        check_bit("dec_valid_o", dec_valid_o, 1'b0);
        drive_cycle(1'b1, 1'b0, '0);
        check_addr("fetch_addr_o", fetch_addr_o, REDIRECT_PC + addr_t'(INSTR_BYTES));
        check_bit("dec_valid_o", dec_valid_o, 1'b1);
        check_addr("dec_pc_o", dec_pc_o, REDIRECT_PC);
        check_instr("dec_instr_o", dec_instr_o, mem_word(REDIRECT_PC));
        end_test("commit redirect");
    endtask

    // commit target beats a jal sitting in decode
    task automatic test_redirect_over_jal();
        addr_t jal_pc;
        start_test();
        drive_cycle(1'b1, 1'b0, '0);
        jal_pc = fetch_addr_o + addr_t'(INSTR_BYTES);
        arm_jal(jal_pc, encode_jal(BACK_IMM));
        drive_cycle(1'b1, 1'b0, '0);
        check_addr("fetch_addr_o", fetch_addr_o, jal_pc);
        // jal still shows on the decode outputs
        drive_cycle(1'b1, 1'b1, PRIO_PC);
        check_bit("dec_valid_o", dec_valid_o, 1'b1);
        check_addr("dec_pc_o", dec_pc_o, jal_pc);
        drive_cycle(1'b1, 1'b0, '0);
        check_addr("fetch_addr_o", fetch_addr_o, PRIO_PC);
        check_bit("dec_valid_o", dec_valid_o, 1'b0);
        drive_cycle(1'b1, 1'b0, '0);
        check_bit("dec_valid_o", dec_valid_o, 1'b1);
        check_addr("dec_pc_o", dec_pc_o, PRIO_PC);
        jal_armed = 1'b0;
        end_test("redirect over jal");
    endtask

    initial begin
        rst_n_i        = 1'b0;
        valid_fetch_i  = 1'b0;
        instr_i        = '0;
        wb_valid_i     = 1'b0;
        wb_change_pc_i = 1'b0;
        wb_target_i    = '0;
        jal_armed      = 1'b0;
        jal_addr       = '0;
        jal_word       = '0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        timed_out      = 1'b0;
        void'($urandom(62));
        test_reset();
        test_sequential();
        if (!timed_out) begin
            test_decode_jal();
            test_commit_redirect();
            test_redirect_over_jal();
        end
        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
